// ==== source/fc_data_pkg.sv ====
package fc_data_pkg;

  // Lanes per stream word and number of MAC lanes
  localparam int NUM_LANES = 4;

  // Requantization: shift right, then clip to the int8 maximum
  localparam int REQ_SHIFT = 6;
  localparam int REQ_MAX = 127;

  // Cycles from a MAC input to its updated sum
  localparam int MAC_LATENCY = 2;

  typedef logic signed [7:0] lane_t;

  // Lane 0 sits in the low byte
  typedef struct packed {
    lane_t lane3;
    lane_t lane2;
    lane_t lane1;
    lane_t lane0;
  } word_t;

  typedef logic signed [27:0] acc_t;

  // One output group, lane 0 in the low bits
  typedef struct packed {
    acc_t acc3;
    acc_t acc2;
    acc_t acc1;
    acc_t acc0;
  } acc_group_t;

  // Read words of the four weight banks
  typedef struct packed {
    word_t bank3;
    word_t bank2;
    word_t bank1;
    word_t bank0;
  } bank_group_t;

endpackage

// ==== source/fc_ctrl_pkg.sv ====
package fc_ctrl_pkg;

  typedef enum logic [1:0] {
    LOAD_FEAT   = 2'd0,
    LOAD_BIAS   = 2'd1,
    LOAD_WEIGHT = 2'd2,
    RUN         = 2'd3
  } opcode_t;

  // Command payload, held stable while cmd_req is high
  typedef struct packed {
    opcode_t op;
  } cmd_t;

  typedef enum logic [3:0] {
    ST_IDLE,
    ST_LOAD,
    ST_READ,
    ST_FEED,
    ST_DRAIN,
    ST_BIAS,
    ST_GO,
    ST_NEXT,
    ST_FINISH,
    ST_ACK
  } ctrl_state_t;

endpackage

// ==== source/word_buffer.sv ====
`timescale 1ns/1ps

module word_buffer #(
  parameter type data_t = logic [31:0],
  parameter int DEPTH = 16,
  localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1
) (
  input  logic          clk,
  input  logic          en,
  input  logic          we,
  input  logic [AW-1:0] addr,
  input  data_t         wdata,
  output data_t         rdata
);

  data_t mem [DEPTH];

  // Read returns the old word when the same address is written
  always_ff @(posedge clk) begin
    if (en) begin
      if (we) begin
        mem[addr] <= wdata;
      end
      rdata <= mem[addr];
    end
  end

endmodule

// ==== source/mac_lane.sv ====
`timescale 1ns/1ps

module mac_lane (
  input  logic              clk,
  input  logic              rstn,
  input  logic              valid,
  input  logic              first,
  input  fc_data_pkg::lane_t feat,
  input  fc_data_pkg::lane_t weight,
  output fc_data_pkg::acc_t  sum
);
  import fc_data_pkg::*;

  logic signed [15:0] prod_q;
  logic               valid_q;
  logic               first_q;

  // Control flags follow the product through stage one
  always_ff @(posedge clk) begin
    if (!rstn) begin
      valid_q <= 1'b0;
      first_q <= 1'b0;
    end else begin
      valid_q <= valid;
      first_q <= valid && first;
    end
  end

  // Stage one multiplies, stage two accumulates
  always_ff @(posedge clk) begin
    prod_q <= feat * weight;
    if (valid_q) begin
      if (first_q) begin
        sum <= acc_t'(prod_q);
      end else begin
        sum <= sum + acc_t'(prod_q);
      end
    end
  end

endmodule

// ==== source/stream_loader.sv ====
`timescale 1ns/1ps

module stream_loader #(
  parameter int IN_WORDS = 4,
  parameter int OUT_GROUPS = 3,
  localparam int AW = (OUT_GROUPS * IN_WORDS > 1) ? $clog2(OUT_GROUPS * IN_WORDS) : 1
) (
  input  logic                 clk,
  input  logic                 rstn,
  input  logic                 load_go,
  input  fc_ctrl_pkg::opcode_t load_op,
  input  logic                 s_valid,
  output logic                 s_ready,
  input  fc_data_pkg::word_t   s_data,
  output logic                 wr_en_feat,
  output logic                 wr_en_bias,
  output logic [3:0]           wr_en_bank,
  output logic [AW-1:0]        wr_addr,
  output fc_data_pkg::word_t   wr_data,
  output logic                 load_done
);
  import fc_data_pkg::*;
  import fc_ctrl_pkg::*;

  localparam int WEIGHT_LEN = NUM_LANES * OUT_GROUPS * IN_WORDS;
  localparam int CW = $clog2(WEIGHT_LEN + 1);

  opcode_t       op_q;
  logic [CW-1:0] cnt;
  logic [CW-1:0] len;
  logic [AW-1:0] col;
  logic [AW-1:0] base;
  logic [1:0]    bank;
  logic          accept;
  logic          last;

  always_comb begin
    case (op_q)
      LOAD_FEAT: len = CW'(IN_WORDS);
      LOAD_BIAS: len = CW'(OUT_GROUPS);
      default:   len = CW'(WEIGHT_LEN);
    endcase
  end

  assign accept    = s_ready && s_valid;
  assign last      = (cnt == len - 1'b1);
  assign load_done = accept && last;
  assign wr_data   = s_data;

  // Weight rows fill one bank each, a full round of banks moves the base
  assign wr_addr    = (op_q == LOAD_WEIGHT) ? base + col : AW'(cnt);
  assign wr_en_feat = accept && (op_q == LOAD_FEAT);
  assign wr_en_bias = accept && (op_q == LOAD_BIAS);
  assign wr_en_bank = (accept && (op_q == LOAD_WEIGHT)) ? 4'(1 << bank) : 4'b0;

  always_ff @(posedge clk) begin
    if (!rstn) begin
      s_ready <= 1'b0;
      op_q    <= LOAD_FEAT;
      cnt     <= '0;
      col     <= '0;
      base    <= '0;
      bank    <= '0;
    end else if (load_go) begin
      s_ready <= 1'b1;
      op_q    <= load_op;
      cnt     <= '0;
      col     <= '0;
      base    <= '0;
      bank    <= '0;
    end else if (accept) begin
      cnt <= cnt + 1'b1;
      if (last) begin
        s_ready <= 1'b0;
      end
      if (col == AW'(IN_WORDS - 1)) begin
        col  <= '0;
        bank <= bank + 1'b1;
        if (bank == 2'(NUM_LANES - 1)) begin
          base <= base + AW'(IN_WORDS);
        end
      end else begin
        col <= col + 1'b1;
      end
    end
  end

endmodule

// ==== source/fc_controller.sv ====
`timescale 1ns/1ps

module fc_controller #(
  parameter int IN_WORDS = 4,
  parameter int OUT_GROUPS = 3,
  localparam int FEAT_AW = (IN_WORDS > 1) ? $clog2(IN_WORDS) : 1,
  localparam int BIAS_AW = (OUT_GROUPS > 1) ? $clog2(OUT_GROUPS) : 1,
  localparam int BANK_AW = (OUT_GROUPS * IN_WORDS > 1) ? $clog2(OUT_GROUPS * IN_WORDS) : 1
) (
  input  logic                     clk,
  input  logic                     rstn,
  input  logic                     cmd_req,
  input  fc_ctrl_pkg::cmd_t        cmd,
  output logic                     cmd_ack,
  output logic                     load_go,
  output fc_ctrl_pkg::opcode_t     load_op,
  input  logic                     load_done,
  output logic [FEAT_AW-1:0]       rd_addr_feat,
  output logic [BANK_AW-1:0]       rd_addr_bank,
  output logic [BIAS_AW-1:0]       rd_addr_bias,
  input  fc_data_pkg::word_t       feat_word,
  input  fc_data_pkg::bank_group_t bank_word,
  input  fc_data_pkg::word_t       bias_rd,
  output logic                     mac_valid,
  output logic                     mac_first,
  output fc_data_pkg::lane_t       mac_feat,
  output fc_data_pkg::word_t       mac_weight,
  output logic                     group_go,
  output fc_data_pkg::word_t       bias_word,
  output logic                     last_group,
  input  logic                     packer_busy,
  input  logic                     run_done
);
  import fc_data_pkg::*;
  import fc_ctrl_pkg::*;

  ctrl_state_t state;
  logic [1:0]  lane_cnt;
  logic [1:0]  drain_cnt;
  logic        last_word;

  assign last_word  = (rd_addr_feat == FEAT_AW'(IN_WORDS - 1));
  assign last_group = (rd_addr_bias == BIAS_AW'(OUT_GROUPS - 1));
  assign group_go   = (state == ST_GO);
  assign bias_word  = bias_rd;

  ////////////////////////////////////////////////////////////////////////////
  // MAC feed, one feature lane per cycle to all four output lanes
  ////////////////////////////////////////////////////////////////////////////

  assign mac_valid = (state == ST_FEED);
  assign mac_first = mac_valid && (rd_addr_feat == '0) && (lane_cnt == '0);
  assign mac_feat  = feat_word[8*lane_cnt +: 8];

  always_comb begin
    for (int k = 0; k < NUM_LANES; k++) begin
      mac_weight[8*k +: 8] = bank_word[32*k + 8*lane_cnt +: 8];
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Command handshake and run sequencing
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rstn) begin
      state        <= ST_IDLE;
      cmd_ack      <= 1'b0;
      load_go      <= 1'b0;
      load_op      <= LOAD_FEAT;
      rd_addr_feat <= '0;
      rd_addr_bank <= '0;
      rd_addr_bias <= '0;
      lane_cnt     <= '0;
      drain_cnt    <= '0;
    end else begin
      load_go <= 1'b0;
      case (state)
        ST_IDLE: begin
          if (cmd_req) begin
            if (cmd.op == RUN) begin
              rd_addr_feat <= '0;
              rd_addr_bank <= '0;
              rd_addr_bias <= '0;
              state        <= ST_READ;
            end else begin
              load_go <= 1'b1;
              load_op <= cmd.op;
              state   <= ST_LOAD;
            end
          end
        end
        ST_LOAD: begin
          if (load_done) begin
            cmd_ack <= 1'b1;
            state   <= ST_ACK;
          end
        end
        // Buffers sample the addresses here, words arrive in ST_FEED
        ST_READ: begin
          lane_cnt <= '0;
          state    <= ST_FEED;
        end
        ST_FEED: begin
          lane_cnt <= lane_cnt + 1'b1;
          if (lane_cnt == 2'(NUM_LANES - 1)) begin
            if (last_word) begin
              drain_cnt <= '0;
              state     <= ST_DRAIN;
            end else begin
              rd_addr_feat <= rd_addr_feat + 1'b1;
              rd_addr_bank <= rd_addr_bank + 1'b1;
              state        <= ST_READ;
            end
          end
        end
        // Let the last products reach the accumulators
        ST_DRAIN: begin
          drain_cnt <= drain_cnt + 1'b1;
          if (drain_cnt == 2'(MAC_LATENCY - 1)) begin
            state <= ST_BIAS;
          end
        end
        ST_BIAS: state <= ST_GO;
        ST_GO: state <= last_group ? ST_FINISH : ST_NEXT;
        // Next group waits until the packer has sent its word
        ST_NEXT: begin
          if (!packer_busy) begin
            rd_addr_feat <= '0;
            rd_addr_bank <= rd_addr_bank + 1'b1;
            rd_addr_bias <= rd_addr_bias + 1'b1;
            state        <= ST_READ;
          end
        end
        ST_FINISH: begin
          if (run_done) begin
            cmd_ack <= 1'b1;
            state   <= ST_ACK;
          end
        end
        ST_ACK: begin
          if (!cmd_req) begin
            cmd_ack <= 1'b0;
            state   <= ST_IDLE;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

endmodule

// ==== source/result_packer.sv ====
`timescale 1ns/1ps

module result_packer (
  input  logic                    clk,
  input  logic                    rstn,
  input  logic                    group_go,
  input  logic                    last_group,
  input  fc_data_pkg::acc_group_t sums,
  input  fc_data_pkg::word_t      bias_word,
  output logic                    m_valid,
  input  logic                    m_ready,
  output fc_data_pkg::word_t      m_data,
  output logic                    m_last,
  output logic                    packer_busy,
  output logic                    run_done,
  output logic [4:0]              max_idx
);
  import fc_data_pkg::*;

  word_t      out_word;
  logic       transfer;
  logic       first_pend;
  logic [2:0] out_grp;
  lane_t      max_val;
  lane_t      cand_val;
  logic [4:0] cand_idx;

  // Bias add, ReLU, shift and clip to int8
  function automatic lane_t requant(acc_t sum, lane_t bias);
    acc_t total;
    acc_t shifted;
    total   = sum + acc_t'(bias);
    shifted = total >>> REQ_SHIFT;
    if (total < 0) begin
      return '0;
    end else if (shifted > REQ_MAX) begin
      return lane_t'(REQ_MAX);
    end
    return lane_t'(shifted);
  endfunction

  always_comb begin
    for (int i = 0; i < NUM_LANES; i++) begin
      out_word[8*i +: 8] = requant(sums[28*i +: 28], bias_word[8*i +: 8]);
    end
  end

  assign transfer    = m_valid && m_ready;
  assign run_done    = transfer && m_last;
  assign packer_busy = m_valid;

  ////////////////////////////////////////////////////////////////////////////
  // Argmax over the word being sent, lower lane wins a tie
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    cand_val = max_val;
    cand_idx = max_idx;
    for (int i = 0; i < NUM_LANES; i++) begin
      if (lane_t'(m_data[8*i +: 8]) > cand_val) begin
        cand_val = lane_t'(m_data[8*i +: 8]);
        cand_idx = {out_grp, 2'(i)};
      end
    end
  end

  always_ff @(posedge clk) begin
    if (group_go) begin
      m_data <= out_word;
    end
  end

  always_ff @(posedge clk) begin
    if (!rstn) begin
      m_valid    <= 1'b0;
      m_last     <= 1'b0;
      first_pend <= 1'b1;
      out_grp    <= '0;
      max_val    <= lane_t'(8'h80);
      max_idx    <= '0;
    end else if (group_go) begin
      m_valid    <= 1'b1;
      m_last     <= last_group;
      first_pend <= 1'b0;
      if (first_pend) begin
        out_grp <= '0;
        max_val <= lane_t'(8'h80);
        max_idx <= '0;
      end else begin
        out_grp <= out_grp + 1'b1;
      end
    end else if (transfer) begin
      m_valid <= 1'b0;
      m_last  <= 1'b0;
      max_val <= cand_val;
      max_idx <= cand_idx;
      // Next group_go starts a new run
      if (m_last) begin
        first_pend <= 1'b1;
      end
    end
  end

endmodule

// ==== source/fc_top.sv ====
`timescale 1ns/1ps

module fc_top #(
  parameter int IN_WORDS = 4,
  parameter int OUT_GROUPS = 3
) (
  input  logic               clk,
  input  logic               rstn,
  input  logic               cmd_req,
  input  fc_ctrl_pkg::cmd_t  cmd,
  output logic               cmd_ack,
  input  logic               s_valid,
  input  fc_data_pkg::word_t s_data,
  output logic               s_ready,
  output logic               m_valid,
  output fc_data_pkg::word_t m_data,
  output logic               m_last,
  input  logic               m_ready,
  output logic [4:0]         max_idx
);
  import fc_data_pkg::*;
  import fc_ctrl_pkg::*;

  localparam int FEAT_AW = (IN_WORDS > 1) ? $clog2(IN_WORDS) : 1;
  localparam int BIAS_AW = (OUT_GROUPS > 1) ? $clog2(OUT_GROUPS) : 1;
  localparam int BANK_AW = (OUT_GROUPS * IN_WORDS > 1) ? $clog2(OUT_GROUPS * IN_WORDS) : 1;

  logic               load_go;
  opcode_t            load_op;
  logic               load_done;
  logic               wr_en_feat;
  logic               wr_en_bias;
  logic [3:0]         wr_en_bank;
  logic [BANK_AW-1:0] wr_addr;
  word_t              wr_data;
  logic [FEAT_AW-1:0] rd_addr_feat;
  logic [BANK_AW-1:0] rd_addr_bank;
  logic [BIAS_AW-1:0] rd_addr_bias;
  word_t              feat_word;
  word_t              bias_rd;
  word_t              bank_rd [NUM_LANES];
  bank_group_t        bank_word;
  logic               mac_valid;
  logic               mac_first;
  lane_t              mac_feat;
  word_t              mac_weight;
  acc_t               lane_sum [NUM_LANES];
  acc_group_t         sums;
  logic               group_go;
  word_t              bias_word;
  logic               last_group;
  logic               packer_busy;
  logic               run_done;

  fc_controller #(.IN_WORDS(IN_WORDS), .OUT_GROUPS(OUT_GROUPS)) u_ctrl (
    .clk, .rstn, .cmd_req, .cmd, .cmd_ack, .load_go, .load_op, .load_done,
    .rd_addr_feat, .rd_addr_bank, .rd_addr_bias, .feat_word, .bank_word, .bias_rd,
    .mac_valid, .mac_first, .mac_feat, .mac_weight, .group_go, .bias_word,
    .last_group, .packer_busy, .run_done
  );

  stream_loader #(.IN_WORDS(IN_WORDS), .OUT_GROUPS(OUT_GROUPS)) u_loader (
    .clk, .rstn, .load_go, .load_op, .s_valid, .s_ready, .s_data,
    .wr_en_feat, .wr_en_bias, .wr_en_bank, .wr_addr, .wr_data, .load_done
  );

  ////////////////////////////////////////////////////////////////////////////
  // Buffers, the write address wins only while that buffer is written
  ////////////////////////////////////////////////////////////////////////////

  word_buffer #(.data_t(word_t), .DEPTH(IN_WORDS)) u_feat_buf (
    .clk, .en(1'b1), .we(wr_en_feat),
    .addr(wr_en_feat ? wr_addr[FEAT_AW-1:0] : rd_addr_feat),
    .wdata(wr_data), .rdata(feat_word)
  );

  word_buffer #(.data_t(word_t), .DEPTH(OUT_GROUPS)) u_bias_buf (
    .clk, .en(1'b1), .we(wr_en_bias),
    .addr(wr_en_bias ? wr_addr[BIAS_AW-1:0] : rd_addr_bias),
    .wdata(wr_data), .rdata(bias_rd)
  );

  for (genvar k = 0; k < NUM_LANES; k++) begin : g_lane
    word_buffer #(.data_t(word_t), .DEPTH(OUT_GROUPS * IN_WORDS)) u_bank_buf (
      .clk, .en(1'b1), .we(wr_en_bank[k]),
      .addr(wr_en_bank[k] ? wr_addr : rd_addr_bank),
      .wdata(wr_data), .rdata(bank_rd[k])
    );

    // Lane k computes output 4g+k of the current group
    mac_lane u_mac (
      .clk, .rstn, .valid(mac_valid), .first(mac_first), .feat(mac_feat),
      .weight(mac_weight[8*k +: 8]), .sum(lane_sum[k])
    );
  end

  assign bank_word = {bank_rd[3], bank_rd[2], bank_rd[1], bank_rd[0]};
  assign sums      = {lane_sum[3], lane_sum[2], lane_sum[1], lane_sum[0]};

  result_packer u_packer (
    .clk, .rstn, .group_go, .last_group, .sums, .bias_word, .m_valid, .m_ready,
    .m_data, .m_last, .packer_busy, .run_done, .max_idx
  );

endmodule

// ==== tb/fc_asserts.sv ====
`timescale 1ns/1ps

module fc_asserts (
  input logic                      clk,
  input logic                      rstn,
  input logic                      cmd_req,
  input logic                      cmd_ack,
  input logic                      s_ready,
  input logic                      m_valid,
  input logic                      m_ready,
  input fc_data_pkg::word_t        m_data,
  input logic                      m_last,
  input fc_ctrl_pkg::ctrl_state_t  ctrl_state
);
  import fc_ctrl_pkg::*;

  // Failures seen so far, read by the testbench at the end
  int unsigned fail_count = 0;

  ////////////////////////////////////////////////////////////////////////////
  // Command handshake
  ////////////////////////////////////////////////////////////////////////////

  ack_needs_req: assert property (
    @(posedge clk) disable iff (!rstn) $rose(cmd_ack) |-> cmd_req
  ) else begin
    fail_count++;
    $error("cmd_ack rose while cmd_req was low");
  end

  ack_holds: assert property (
    @(posedge clk) disable iff (!rstn) cmd_ack && cmd_req |=> cmd_ack
  ) else begin
    fail_count++;
    $error("cmd_ack dropped while cmd_req was still high");
  end

  ack_falls_after_req: assert property (
    @(posedge clk) disable iff (!rstn) $fell(cmd_ack) |-> $past(!cmd_req)
  ) else begin
    fail_count++;
    $error("cmd_ack fell before cmd_req had fallen");
  end

  // Input stream is only open during a load
  ready_in_load: assert property (
    @(posedge clk) disable iff (!rstn) s_ready |-> ctrl_state == ST_LOAD
  ) else begin
    fail_count++;
    $error("s_ready was high outside a load command");
  end

  ////////////////////////////////////////////////////////////////////////////
  // Output stream
  ////////////////////////////////////////////////////////////////////////////

  out_stable: assert property (
    @(posedge clk) disable iff (!rstn)
      m_valid && !m_ready |=> m_valid && $stable(m_data) && $stable(m_last)
  ) else begin
    fail_count++;
    $error("Output word changed or was withdrawn under back-pressure");
  end

  // Reset values show up one edge after rstn is seen low
  reset_quiet: assert property (
    @(posedge clk) !rstn |=> !cmd_ack && !s_ready && !m_valid && !m_last
  ) else begin
    fail_count++;
    $error("cmd_ack, s_ready, m_valid or m_last not low after reset");
  end

endmodule

bind fc_top fc_asserts fc_asserts_inst (
  .clk        (clk),
  .rstn       (rstn),
  .cmd_req    (cmd_req),
  .cmd_ack    (cmd_ack),
  .s_ready    (s_ready),
  .m_valid    (m_valid),
  .m_ready    (m_ready),
  .m_data     (m_data),
  .m_last     (m_last),
  .ctrl_state (u_ctrl.state)
);

// ==== tb/tb_fc_top.sv ====
`timescale 1ns/1ps

module tb_fc_top;
  import fc_data_pkg::*;
  import fc_ctrl_pkg::*;

  localparam int IN_WORDS = 4;
  localparam int OUT_GROUPS = 3;
  localparam int OUT_NEURONS = NUM_LANES * OUT_GROUPS;
  localparam int CLK_PERIOD = 40;
  localparam int RESET_CYCLES = 5;
  // Two load and run passes need well under 1000 cycles with random stalls
  localparam int TIMEOUT_CYCLES = 4000;

  logic       clk = 1'b0;
  logic       rstn;
  logic       cmd_req;
  cmd_t       cmd;
  logic       cmd_ack;
  logic       s_valid;
  word_t      s_data;
  logic       s_ready;
  logic       m_valid;
  word_t      m_data;
  logic       m_last;
  logic       m_ready;
  logic [4:0] max_idx;

  integer     seed = 32'h3f46;
  int         cycle_count = 0;
  int         word_errors = 0;
  int         run_errors = 0;
  int         words_seen = 0;
  int         out_cnt = 0;

  // Buffer contents as the host sees them
  word_t      feat_mem [IN_WORDS];
  word_t      bias_mem [OUT_GROUPS];
  word_t      weight_mem [OUT_NEURONS][IN_WORDS];

  word_t      exp_words [OUT_GROUPS];
  logic [4:0] exp_max_idx;

  always #(CLK_PERIOD / 2) clk = ~clk;

  fc_top #(.IN_WORDS(IN_WORDS), .OUT_GROUPS(OUT_GROUPS)) fc_top_inst (
    .clk, .rstn, .cmd_req, .cmd, .cmd_ack, .s_valid, .s_data, .s_ready,
    .m_valid, .m_data, .m_last, .m_ready, .max_idx
  );

  ////////////////////////////////////////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////////////////////////////////////////

  function automatic int lane_of(word_t w, int b);
    logic signed [7:0] v;
    v = w[8*b +: 8];
    return v;
  endfunction

  // Dot product plus bias, then ReLU, shift and saturation
  function automatic int neuron_out(int o);
    int total;
    total = lane_of(bias_mem[o / NUM_LANES], o % NUM_LANES);
    for (int w = 0; w < IN_WORDS; w++) begin
      for (int b = 0; b < NUM_LANES; b++) begin
        total += lane_of(feat_mem[w], b) * lane_of(weight_mem[o][w], b);
      end
    end
    if (total < 0) begin
      return 0;
    end
    total = total >> REQ_SHIFT;
    return (total > REQ_MAX) ? REQ_MAX : total;
  endfunction

  // First index of the largest output wins
  task automatic compute_model();
    int val;
    int best;
    best = -128;
    exp_max_idx = '0;
    for (int o = 0; o < OUT_NEURONS; o++) begin
      val = neuron_out(o);
      exp_words[o / NUM_LANES][8*(o % NUM_LANES) +: 8] = 8'(val);
      if (val > best) begin
        best = val;
        exp_max_idx = 5'(o);
      end
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus data
  ////////////////////////////////////////////////////////////////////////////

  task automatic fill_random();
    for (int w = 0; w < IN_WORDS; w++) begin
      feat_mem[w] = $random(seed);
    end
    for (int g = 0; g < OUT_GROUPS; g++) begin
      bias_mem[g] = $random(seed);
    end
    for (int o = 0; o < OUT_NEURONS; o++) begin
      for (int w = 0; w < IN_WORDS; w++) begin
        weight_mem[o][w] = $random(seed);
      end
    end
  endtask

  // Large positive features; weights push outputs to 127, to 0, or anywhere
  task automatic fill_extreme();
    int mag;
    for (int w = 0; w < IN_WORDS; w++) begin
      for (int b = 0; b < NUM_LANES; b++) begin
        feat_mem[w][8*b +: 8] = 8'(64 + ($random(seed) & 63));
      end
    end
    for (int g = 0; g < OUT_GROUPS; g++) begin
      bias_mem[g] = $random(seed);
    end
    for (int o = 0; o < OUT_NEURONS; o++) begin
      for (int w = 0; w < IN_WORDS; w++) begin
        for (int b = 0; b < NUM_LANES; b++) begin
          mag = 64 + ($random(seed) & 63);
          case (o % 3)
            0: weight_mem[o][w][8*b +: 8] = 8'(mag);
            1: weight_mem[o][w][8*b +: 8] = 8'(-mag);
            default: weight_mem[o][w][8*b +: 8] = 8'($random(seed));
          endcase
        end
      end
    end
  endtask

  function automatic word_t stream_word(opcode_t op, int idx);
    case (op)
      LOAD_FEAT: return feat_mem[idx];
      LOAD_BIAS: return bias_mem[idx];
      default:   return weight_mem[idx / IN_WORDS][idx % IN_WORDS];
    endcase
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Host commands
  ////////////////////////////////////////////////////////////////////////////

  task automatic load_buffer(input opcode_t op);
    int len;
    int sent;
    case (op)
      LOAD_FEAT: len = IN_WORDS;
      LOAD_BIAS: len = OUT_GROUPS;
      default:   len = OUT_NEURONS * IN_WORDS;
    endcase
    sent = 0;
    @(posedge clk);
    cmd_req <= 1'b1;
    cmd.op  <= op;
    while (!cmd_ack) begin
      @(posedge clk);
      if (s_valid && s_ready) begin
        sent++;
      end
      if (sent >= len) begin
        s_valid <= 1'b0;
      end else if (!s_valid || s_ready) begin
        // Hold an offered word until it is taken
        s_valid <= (($random(seed) & 3) != 0);
        s_data  <= stream_word(op, sent);
      end
    end
    assert (sent == len) else begin
      run_errors++;
      $display("Load %s took %0d words instead of %0d", op.name(), sent, len);
    end
    cmd_req <= 1'b0;
    s_valid <= 1'b0;
    while (cmd_ack) begin
      @(posedge clk);
    end
  endtask

  task automatic run_layer();
    compute_model();
    @(posedge clk);
    cmd_req <= 1'b1;
    cmd.op  <= RUN;
    while (!cmd_ack) begin
      @(posedge clk);
      m_ready <= $random(seed) & 1;
    end
    assert (max_idx == exp_max_idx) else begin
      run_errors++;
      $display("[FAIL] %0t max_idx expected %0d actual %0d", $time, exp_max_idx, max_idx);
    end
    cmd_req <= 1'b0;
    m_ready <= 1'b0;
    while (cmd_ack) begin
      @(posedge clk);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Output word checks
  ////////////////////////////////////////////////////////////////////////////

  always @(posedge clk) begin
    if (rstn && m_valid && m_ready) begin
      assert (m_data == exp_words[out_cnt]) else begin
        word_errors++;
        $display("[FAIL] %0t m_data expected %h actual %h", $time, exp_words[out_cnt],
                 m_data);
      end
      assert (m_last == (out_cnt == OUT_GROUPS - 1)) else begin
        word_errors++;
        $display("[FAIL] %0t m_last expected %b actual %b", $time,
                 (out_cnt == OUT_GROUPS - 1), m_last);
      end
      words_seen++;
      out_cnt = (out_cnt + 1) % OUT_GROUPS;
    end
  end

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("Timeout after %0d cycles, a command never completed", cycle_count);
      $display("SIMULATION FAILED");
      $finish;
    end
  end

  initial begin
    int total;
    rstn    = 1'b0;
    cmd_req = 1'b0;
    cmd     = '0;
    s_valid = 1'b0;
    s_data  = '0;
    m_ready = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    rstn <= 1'b1;

    fill_random();
    load_buffer(LOAD_FEAT);
    load_buffer(LOAD_BIAS);
    load_buffer(LOAD_WEIGHT);
    run_layer();

    fill_extreme();
    load_buffer(LOAD_FEAT);
    load_buffer(LOAD_BIAS);
    load_buffer(LOAD_WEIGHT);
    run_layer();

    repeat (4) @(posedge clk);
    assert (words_seen == 2 * OUT_GROUPS) else begin
      run_errors++;
      $display("Saw %0d output words instead of %0d", words_seen, 2 * OUT_GROUPS);
    end

    total = word_errors + run_errors + fc_top_inst.fc_asserts_inst.fail_count;
    $display("Errors: output words %0d, runs %0d, protocol %0d", word_errors, run_errors,
             fc_top_inst.fc_asserts_inst.fail_count);
    if (total == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

// ==== compile.f ====
source/fc_data_pkg.sv
source/fc_ctrl_pkg.sv
source/word_buffer.sv
source/mac_lane.sv
source/stream_loader.sv
source/fc_controller.sv
source/result_packer.sv
source/fc_top.sv
tb/fc_asserts.sv
tb/tb_fc_top.sv

// ==== Bender.yml ====
package:
  name: fc_layer

sources:
  - source/fc_data_pkg.sv
  - source/fc_ctrl_pkg.sv
  - source/word_buffer.sv
  - source/mac_lane.sv
  - source/stream_loader.sv
  - source/fc_controller.sv
  - source/result_packer.sv
  - source/fc_top.sv
  - target: test
    files:
      - tb/fc_asserts.sv
      - tb/tb_fc_top.sv
